//--- src/isa_pkg.sv
package isa_pkg;

   localparam int DATA_W = 32;
   localparam int REG_AW = 3;
   localparam int IMM8_W = 8;

   // instruction field positions
   localparam int RD_LSB   = 16;   // destination register
   localparam int IMM8_LSB = 8;
   localparam int SUB_LSB  = 19;   // sub-op of the 0x81/0x83 group
   localparam int CC_LSB   = 16;   // low nibble of the 0x7x jcc opcode
   localparam int SEXT_BIT = 25;   // 0x83 sign-extends, 0x81 does not

   // widths of the opcode prefixes that are matched
   localparam int OP10_W = 10;
   localparam int OP12_W = 12;
   localparam int OP13_W = 13;
   localparam int OP16_W = 16;

   typedef enum logic [5:0] {
      ld_imm, mov,
      add, sub, cmp, and_op, or_op, xor_op,
      add_i, sub_i, cmp_i, and_i, or_i, xor_i,
      neg, not_op, shl, shr, sar,
      jmp, jcc, jmp_r, nop
   } op_e;

   // value is the low nibble of the x86 jcc opcode
   typedef enum logic [3:0] {
      of_set   = 4'h0, of_clr   = 4'h1,
      cf_set   = 4'h2, cf_clr   = 4'h3,
      zf_set   = 4'h4, zf_clr   = 4'h5,
      cz_set   = 4'h6, cz_clr   = 4'h7,
      sf_set   = 4'h8, sf_clr   = 4'h9,
      sxo_set  = 4'hc, sxo_clr  = 4'hd,
      sxoz_set = 4'he, sxoz_clr = 4'hf
   } cond_e;

   localparam logic [OP10_W-1:0] PAT_MOV   = 10'b1000_1001_11;
   localparam logic [OP10_W-1:0] PAT_ADD   = 10'b0000_0001_11;
   localparam logic [OP10_W-1:0] PAT_SUB   = 10'b0010_1001_11;
   localparam logic [OP10_W-1:0] PAT_CMP   = 10'b0011_1001_11;
   localparam logic [OP10_W-1:0] PAT_AND   = 10'b0010_0001_11;
   localparam logic [OP10_W-1:0] PAT_OR    = 10'b0000_1001_11;
   localparam logic [OP10_W-1:0] PAT_XOR   = 10'b0011_0001_11;
   localparam logic [OP10_W-1:0] PAT_IMM_Z = 10'b1000_0001_11;
   localparam logic [OP10_W-1:0] PAT_IMM_S = 10'b1000_0011_11;

   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b001;
   localparam logic [2:0] SUB_AND = 3'b100;
   localparam logic [2:0] SUB_SUB = 3'b101;
   localparam logic [2:0] SUB_XOR = 3'b110;
   localparam logic [2:0] SUB_CMP = 3'b111;

   localparam logic [OP13_W-1:0] PAT_LD_IMM = 13'b0110_0110_10_111;
   localparam logic [OP13_W-1:0] PAT_NEG    = 13'b1111_0111_11_011;
   localparam logic [OP13_W-1:0] PAT_NOT    = 13'b1111_0111_11_010;
   localparam logic [OP13_W-1:0] PAT_SHL    = 13'b1100_0001_11_100;
   localparam logic [OP13_W-1:0] PAT_SHR    = 13'b1100_0001_11_101;
   localparam logic [OP13_W-1:0] PAT_SAR    = 13'b1100_0001_11_111;
   localparam logic [OP13_W-1:0] PAT_JMP_R  = 13'b1111_1111_11_100;

   localparam logic [OP12_W-1:0] PAT_JCC = 12'b1001_0000_0111;
   localparam logic [OP16_W-1:0] PAT_JMP = 16'b1001_0000_1110_1011;
   localparam logic [OP16_W-1:0] PAT_NOP = 16'b1001_0000_1001_0000;

endpackage

//--- src/exec_pkg.sv
package exec_pkg;

   // decoded instruction, shared by all execute sub-blocks
   typedef struct packed {
      isa_pkg::op_e                    op;
      logic                            sext;   // imm8 sign-extended
      isa_pkg::cond_e                  cc;
      logic [isa_pkg::IMM8_W-1:0]      imm8;
      logic [2*isa_pkg::IMM8_W-1:0]    im16;   // bytes already swapped
   } dec_op_t;

   typedef struct packed {
      logic sf;
      logic zf;
      logic cf;
      logic of;
   } flags_t;

   // register file write request
   typedef struct packed {
      logic                         we;
      logic [isa_pkg::REG_AW-1:0]   wa;
   } wb_ctrl_t;

endpackage

//--- src/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder
   import isa_pkg::*, exec_pkg::*;
(
   input  logic              clk,
   input  logic              n_rst,
   input  logic              we,
   input  logic [DATA_W-1:0] ir,
   output dec_op_t           dec,
   output wb_ctrl_t          wb
);

   logic [OP10_W-1:0] op10;
   logic [OP12_W-1:0] op12;
   logic [OP13_W-1:0] op13;
   logic [OP16_W-1:0] op16;
   logic              cc_ok;
   op_e               op;
   cond_e             cc;

   assign op10  = ir[DATA_W-1 -: OP10_W];
   assign op12  = ir[DATA_W-1 -: OP12_W];
   assign op13  = ir[DATA_W-1 -: OP13_W];
   assign op16  = ir[DATA_W-1 -: OP16_W];
   assign cc_ok = (ir[CC_LSB+1 +: 3] != 3'b101);   // 7a/7b parity jumps not kept

   always_comb begin
      op = nop;
      cc = of_set;
      if (op16 == PAT_JMP) begin
         op = jmp;
      end else if (op16 == PAT_NOP) begin
         op = nop;
      end else if (op12 == PAT_JCC && cc_ok) begin
         op = jcc;
         cc = cond_e'(ir[CC_LSB +: 4]);
      end else if (op13 == PAT_LD_IMM) begin
         op = ld_imm;
      end else if (op10 == PAT_IMM_Z || op10 == PAT_IMM_S) begin
         case (ir[SUB_LSB +: 3])
            SUB_ADD: op = add_i;
            SUB_SUB: op = sub_i;
            SUB_CMP: op = cmp_i;
            SUB_AND: op = and_i;
            SUB_OR:  op = or_i;
            SUB_XOR: op = xor_i;
            default: op = nop;
         endcase
      end else begin
         case (op13)
            PAT_NEG:   op = neg;
            PAT_NOT:   op = not_op;
            PAT_SHL:   op = shl;
            PAT_SHR:   op = shr;
            PAT_SAR:   op = sar;
            PAT_JMP_R: op = jmp_r;
            default: begin
               case (op10)
                  PAT_MOV: op = mov;
                  PAT_ADD: op = add;
                  PAT_SUB: op = sub;
                  PAT_CMP: op = cmp;
                  PAT_AND: op = and_op;
                  PAT_OR:  op = or_op;
                  PAT_XOR: op = xor_op;
                  default: op = nop;   // unknown word
               endcase
            end
         endcase
      end
   end

   assign dec.op   = op;
   assign dec.sext = ir[SEXT_BIT];
   assign dec.cc   = cc;
   assign dec.imm8 = ir[IMM8_LSB +: IMM8_W];
   assign dec.im16 = {ir[IMM8_W-1:0], ir[IMM8_LSB +: IMM8_W]};

   always_ff @(posedge clk or negedge n_rst) begin
      if (!n_rst) begin
         wb <= '0;
      end else if (we) begin
         wb.we <= op inside {ld_imm, mov, add, sub, and_op, or_op, xor_op,
                             add_i, sub_i, and_i, or_i, xor_i,
                             neg, not_op, shl, shr, sar};   // cmp forms excluded
         wb.wa <= ir[RD_LSB +: REG_AW];
      end
   end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu
   import isa_pkg::*, exec_pkg::*;
(
   input  logic              clk,
   input  logic              n_rst,
   input  logic              we,
   input  dec_op_t           dec,
   input  logic [DATA_W-1:0] sr,
   input  logic [DATA_W-1:0] tr,
   input  logic [DATA_W-1:0] pc,
   output logic [DATA_W-1:0] res,
   output logic              carry,
   output logic              ovf,
   output logic [DATA_W-1:0] dr
);

   logic [DATA_W-1:0]      imm_x;
   logic [DATA_W-1:0]      src_b;
   logic [DATA_W-1:0]      disp;
   logic                   reg_form;
   logic                   is_sub;
   logic [DATA_W:0]        sum;
   logic                   sum_ovf;
   logic [DATA_W:0]        shl_x;
   logic [DATA_W:0]        shr_x;
   logic signed [DATA_W:0] sar_x;

   assign imm_x = dec.sext ? {{(DATA_W-IMM8_W){dec.imm8[IMM8_W-1]}}, dec.imm8}
                           : {{(DATA_W-IMM8_W){1'b0}}, dec.imm8};

   assign reg_form = dec.op inside {add, sub, cmp, and_op, or_op, xor_op};
   assign src_b    = reg_form ? sr : imm_x;
   assign is_sub   = dec.op inside {sub, cmp, sub_i, cmp_i};

   // tr is always the left operand, bit 32 is carry or borrow
   assign sum     = is_sub ? {1'b0, tr} - {1'b0, src_b} : {1'b0, tr} + {1'b0, src_b};
   assign sum_ovf = ((tr[DATA_W-1] ^ src_b[DATA_W-1]) == is_sub)
                    && (sum[DATA_W-1] != tr[DATA_W-1]);

   // one extra bit catches the last bit shifted out
   assign shl_x = {1'b0, tr} << dec.imm8;
   assign shr_x = {tr, 1'b0} >> dec.imm8;
   assign sar_x = $signed({tr, 1'b0}) >>> dec.imm8;

   assign disp = $signed({{(DATA_W-IMM8_W){dec.imm8[IMM8_W-1]}}, dec.imm8}
                         + DATA_W'(3)) >>> 2;

   always_comb begin
      case (dec.op)
         ld_imm:                             res = {tr[DATA_W-1:DATA_W/2], dec.im16};
         mov:                                res = sr;
         add, sub, cmp, add_i, sub_i, cmp_i: res = sum[DATA_W-1:0];
         and_op, and_i:                      res = tr & src_b;
         or_op, or_i:                        res = tr | src_b;
         xor_op, xor_i:                      res = tr ^ src_b;
         neg:                                res = -tr;
         not_op:                             res = ~tr;
         shl:                                res = shl_x[DATA_W-1:0];
         shr:                                res = shr_x[DATA_W:1];
         sar:                                res = sar_x[DATA_W:1];
         jmp, jcc:                           res = pc + disp;   // branch target
         jmp_r:                              res = tr;
         default:                            res = '0;
      endcase
   end

   // raw side outputs, flag_unit decides which ones stick
   always_comb begin
      carry = sum[DATA_W];
      ovf   = sum_ovf;
      case (dec.op)
         shl: begin
            carry = shl_x[DATA_W];
            ovf   = tr[DATA_W-1] ^ shl_x[DATA_W-1];
         end
         shr:     carry = shr_x[0];
         sar:     carry = sar_x[0];
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge n_rst) begin
      if (!n_rst) begin
         dr <= '0;
      end else if (we && dec.op != nop) begin
         dr <= res;
      end
   end

endmodule

//--- src/flag_unit.sv
`timescale 1ns/1ps

module flag_unit
   import isa_pkg::*, exec_pkg::*;
(
   input  logic              clk,
   input  logic              n_rst,
   input  logic              we,
   input  dec_op_t           dec,
   input  logic [DATA_W-1:0] res,
   input  logic              carry,
   input  logic              ovf,
   output flags_t            flags
);

   logic set_flags;
   logic keep_cf;
   logic keep_of;

   always_comb begin
      set_flags = 1'b1;
      keep_cf   = 1'b0;
      keep_of   = 1'b0;
      case (dec.op)
         add, sub, cmp, add_i, sub_i, cmp_i, shl: begin
            keep_cf = 1'b1;
            keep_of = 1'b1;
         end
         shr, sar:                                           keep_cf = 1'b1;
         and_op, or_op, xor_op, and_i, or_i, xor_i, neg, not_op: ;   // cf, of cleared
         default:                                            set_flags = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge n_rst) begin
      if (!n_rst) begin
         flags <= '0;
      end else if (we && set_flags) begin
         flags.sf <= res[DATA_W-1];
         flags.zf <= (res == '0);
         flags.cf <= carry & keep_cf;
         flags.of <= ovf & keep_of;
      end
   end

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
   import isa_pkg::*, exec_pkg::*;
(
   input  logic    clk,
   input  logic    n_rst,
   input  logic    we,
   input  dec_op_t dec,
   input  flags_t  flags,
   output logic    jump
);

   logic taken;
   logic lt;

   assign lt = flags.sf ^ flags.of;   // signed less than

   always_comb begin
      case (dec.cc)
         of_set:   taken = flags.of;
         of_clr:   taken = ~flags.of;
         cf_set:   taken = flags.cf;
         cf_clr:   taken = ~flags.cf;
         zf_set:   taken = flags.zf;
         zf_clr:   taken = ~flags.zf;
         cz_set:   taken = flags.cf | flags.zf;
         cz_clr:   taken = ~(flags.cf | flags.zf);
         sf_set:   taken = flags.sf;
         sf_clr:   taken = ~flags.sf;
         sxo_set:  taken = lt;
         sxo_clr:  taken = ~lt;
         sxoz_set: taken = lt | flags.zf;
         sxoz_clr: taken = ~(lt | flags.zf);
         default:  taken = 1'b0;
      endcase
   end

   // flags here are the ones held before this edge
   always_ff @(posedge clk or negedge n_rst) begin
      if (!n_rst) begin
         jump <= 1'b0;
      end else if (we) begin
         case (dec.op)
            jmp, jmp_r: jump <= 1'b1;
            jcc:        jump <= taken;
            default:    jump <= 1'b0;
         endcase
      end
   end

endmodule

//--- src/execute.sv
`timescale 1ns/1ps

module execute
   import isa_pkg::*, exec_pkg::*;
(
   input  logic              clk,
   input  logic              n_rst,
   input  logic              we,
   input  logic [DATA_W-1:0] ir,
   input  logic [DATA_W-1:0] sr,
   input  logic [DATA_W-1:0] tr,
   input  logic [DATA_W-1:0] pc,
   output logic [DATA_W-1:0] dr,
   output wb_ctrl_t          wb,
   output logic              jump
);

   dec_op_t           dec;
   logic [DATA_W-1:0] res;
   logic              carry;
   logic              ovf;
   flags_t            flags;

   insn_decoder u_dec (
      .clk(clk), .n_rst(n_rst), .we(we), .ir(ir), .dec(dec), .wb(wb)
   );

   alu u_alu (
      .clk(clk), .n_rst(n_rst), .we(we), .dec(dec),
      .sr(sr), .tr(tr), .pc(pc),
      .res(res), .carry(carry), .ovf(ovf), .dr(dr)
   );

   flag_unit u_flags (
      .clk(clk), .n_rst(n_rst), .we(we), .dec(dec),
      .res(res), .carry(carry), .ovf(ovf), .flags(flags)
   );

   branch_unit u_branch (
      .clk(clk), .n_rst(n_rst), .we(we), .dec(dec), .flags(flags), .jump(jump)
   );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #20 clk = ~clk;   // 40 ns period

endmodule

//--- sim/execute_tb.sv
`timescale 1ns/1ps

module execute_tb
   import isa_pkg::*, exec_pkg::*;
();

   localparam int MAX_CYCLES = 600;   // about twice the cycles the tests use

   logic              clk;
   logic              n_rst;
   logic              we;
   logic [DATA_W-1:0] ir;
   logic [DATA_W-1:0] sr;
   logic [DATA_W-1:0] tr;
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] dr;
   wb_ctrl_t          wb;
   logic              jump;

   logic [31:0]       rng_state;
   int                cycles = 0;
   int                n_checks;
   int                n_errors;
   int                n_tests;

   // reference state once every issued instruction is captured
   logic [DATA_W-1:0] m_dr;
   wb_ctrl_t          m_wb;
   logic              m_jump;
   flags_t            m_flags;

   tb_clock u_clk (.clk(clk));

   execute uut (
      .clk(clk), .n_rst(n_rst), .we(we), .ir(ir), .sr(sr), .tr(tr), .pc(pc),
      .dr(dr), .wb(wb), .jump(jump)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check_data(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_wb(string name, wb_ctrl_t got, wb_ctrl_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR %0t ns %s got we=%b wa=%0d expected we=%b wa=%0d",
                  $time, name, got.we, got.wa, exp.we, exp.wa);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   function automatic logic cond_taken(cond_e cc, flags_t f);
      logic base;
      case (cc[3:1])
         3'd0:    base = f.of;
         3'd1:    base = f.cf;
         3'd2:    base = f.zf;
         3'd3:    base = f.cf | f.zf;
         3'd4:    base = f.sf;
         3'd6:    base = f.sf ^ f.of;
         default: base = (f.sf ^ f.of) | f.zf;
      endcase
      return base ^ cc[0];   // odd codes are the negated test
   endfunction

   function automatic logic [DATA_W-1:0] encode(op_e op, logic sext, cond_e cc,
                                                logic [7:0] imm8);
      logic [31:0] fill;
      logic [9:0]  ipat;
      logic [31:0] w;
      fill = next_rand();   // don't-care bits
      ipat = sext ? PAT_IMM_S : PAT_IMM_Z;
      case (op)
         mov:     w = {PAT_MOV, fill[21:0]};
         add:     w = {PAT_ADD, fill[21:0]};
         sub:     w = {PAT_SUB, fill[21:0]};
         cmp:     w = {PAT_CMP, fill[21:0]};
         and_op:  w = {PAT_AND, fill[21:0]};
         or_op:   w = {PAT_OR, fill[21:0]};
         xor_op:  w = {PAT_XOR, fill[21:0]};
         add_i:   w = {ipat, SUB_ADD, fill[18:16], imm8, fill[7:0]};
         sub_i:   w = {ipat, SUB_SUB, fill[18:16], imm8, fill[7:0]};
         cmp_i:   w = {ipat, SUB_CMP, fill[18:16], imm8, fill[7:0]};
         and_i:   w = {ipat, SUB_AND, fill[18:16], imm8, fill[7:0]};
         or_i:    w = {ipat, SUB_OR, fill[18:16], imm8, fill[7:0]};
         xor_i:   w = {ipat, SUB_XOR, fill[18:16], imm8, fill[7:0]};
         ld_imm:  w = {PAT_LD_IMM, fill[18:16], imm8, fill[7:0]};
         neg:     w = {PAT_NEG, fill[18:16], imm8, fill[7:0]};
         not_op:  w = {PAT_NOT, fill[18:16], imm8, fill[7:0]};
         shl:     w = {PAT_SHL, fill[18:16], imm8, fill[7:0]};
         shr:     w = {PAT_SHR, fill[18:16], imm8, fill[7:0]};
         sar:     w = {PAT_SAR, fill[18:16], imm8, fill[7:0]};
         jmp_r:   w = {PAT_JMP_R, fill[18:16], imm8, fill[7:0]};
         jmp:     w = {PAT_JMP, imm8, fill[7:0]};
         jcc:     w = {PAT_JCC, cc, imm8, fill[7:0]};
         default: w = {PAT_NOP, fill[15:0]};
      endcase
      return w;
   endfunction

   task automatic model_apply(logic [DATA_W-1:0] iw, op_e op, logic sext,
                              logic [DATA_W-1:0] s, logic [DATA_W-1:0] t,
                              logic [DATA_W-1:0] p);
      logic [DATA_W-1:0]        imm;
      logic [DATA_W-1:0]        b;
      logic [DATA_W-1:0]        r;
      logic [DATA_W:0]          wide;
      logic signed [DATA_W-1:0] d;
      logic                     c;
      logic                     v;
      int                       n;
      imm = sext ? {{24{iw[15]}}, iw[15:8]} : {24'h0, iw[15:8]};
      b   = (op inside {add, sub, cmp, and_op, or_op, xor_op}) ? s : imm;
      n   = int'(iw[15:8]);
      d   = {{24{iw[15]}}, iw[15:8]};
      d   = (d + 32'sd3) >>> 2;   // jump displacement
      r   = '0;
      c   = 1'b0;
      v   = 1'b0;
      case (op)
         ld_imm:        r = {t[31:16], iw[7:0], iw[15:8]};
         mov:           r = s;
         add, add_i: begin
            wide = {1'b0, t} + {1'b0, b};
            r    = wide[31:0];
            c    = wide[32];
            v    = (t[31] == b[31]) && (r[31] != t[31]);
         end
         sub, cmp, sub_i, cmp_i: begin
            r = t - b;
            c = (t < b);   // borrow
            v = (t[31] != b[31]) && (r[31] != t[31]);
         end
         and_op, and_i: r = t & b;
         or_op, or_i:   r = t | b;
         xor_op, xor_i: r = t ^ b;
         neg:           r = -t;
         not_op:        r = ~t;
         shl: begin
            r = t << n;
            c = t[32-n];
            v = t[31] ^ r[31];
         end
         shr: begin
            r = t >> n;
            c = t[n-1];
         end
         sar: begin
            r = $signed(t) >>> n;
            c = t[n-1];
         end
         jmp, jcc:      r = p + d;
         jmp_r:         r = t;
         default:       ;
      endcase
      m_jump  = (op == jmp) || (op == jmp_r)
                || (op == jcc && cond_taken(cond_e'(iw[19:16]), m_flags));
      m_wb.we = op inside {ld_imm, mov, add, sub, and_op, or_op, xor_op, add_i, sub_i,
                           and_i, or_i, xor_i, neg, not_op, shl, shr, sar};
      m_wb.wa = iw[18:16];
      if (op != nop) begin
         m_dr = r;
      end
      if (op inside {add, sub, cmp, and_op, or_op, xor_op, add_i, sub_i, cmp_i, and_i,
                     or_i, xor_i, neg, not_op, shl, shr, sar}) begin
         m_flags = {r[31], r == '0, c, v};
      end
   endtask

   // drive one cycle, check what the previous edge captured
   task automatic issue(logic w, logic [DATA_W-1:0] iw, op_e op, logic sext,
                        logic [DATA_W-1:0] s, logic [DATA_W-1:0] t,
                        logic [DATA_W-1:0] p);
      @(posedge clk);
      we <= w;
      ir <= iw;
      sr <= s;
      tr <= t;
      pc <= p;
      @(negedge clk);
      check_data("dr", dr, m_dr);
      check_wb("wb", wb, m_wb);
      check_bit("jump", jump, m_jump);
      if (w) begin
         model_apply(iw, op, sext, s, t, p);
      end
   endtask

   task automatic run(op_e op, logic sext, cond_e cc, logic [7:0] imm8,
                      logic [DATA_W-1:0] s, logic [DATA_W-1:0] t);
      issue(1'b1, encode(op, sext, cc, imm8), op, sext, s, t, next_rand());
   endtask

   task automatic hold_cycle();
      issue(1'b0, next_rand(), nop, 1'b0, next_rand(), next_rand(), next_rand());
   endtask

   task automatic report_test(string name, int errs_before);
      n_tests++;
      $display("%-10s %s, %0d errors", name, (n_errors == errs_before) ? "ok" : "failed",
               n_errors - errs_before);
   endtask

   task automatic after_reset();
      int e0;
      e0 = n_errors;
      hold_cycle();
      report_test("reset", e0);
   endtask

   task automatic reg_forms();
      op_e ops[7];
      int  e0;
      ops = '{mov, add, sub, cmp, and_op, or_op, xor_op};
      e0  = n_errors;
      foreach (ops[i]) begin
         for (int k = 0; k < 20; k++) begin
            run(ops[i], 1'b0, of_set, 8'(next_rand()), next_rand(), next_rand());
         end
      end
      hold_cycle();
      report_test("reg_ops", e0);
   endtask

   task automatic imm_forms();
      op_e        imm_ops[6];
      op_e        one_ops[6];
      logic [7:0] imm;
      int         e0;
      imm_ops = '{add_i, sub_i, cmp_i, and_i, or_i, xor_i};
      one_ops = '{ld_imm, neg, not_op, shl, shr, sar};
      e0      = n_errors;
      foreach (imm_ops[i]) begin
         for (int k = 0; k < 8; k++) begin
            imm    = 8'(next_rand());
            imm[7] = k[1];   // both signs of imm8
            run(imm_ops[i], k[0], of_set, imm, next_rand(), next_rand());
         end
      end
      foreach (one_ops[i]) begin
         for (int k = 0; k < 4; k++) begin
            imm = 8'(1 + next_rand() % 31);   // shift count 1..31
            run(one_ops[i], 1'b0, of_set, imm, next_rand(), next_rand());
         end
      end
      hold_cycle();
      report_test("imm_ops", e0);
   endtask

   task automatic cond_jumps();
      logic [DATA_W-1:0] v;
      int                e0;
      e0 = n_errors;
      for (int i = 0; i < 16; i++) begin
         if (i == 10 || i == 11) begin
            continue;   // parity jumps not decoded
         end
         v = next_rand();
         run(cmp, 1'b0, of_set, 8'h00, v, v);
         run(jcc, 1'b0, cond_e'(i), 8'(next_rand()), next_rand(), next_rand());
         run(cmp, 1'b0, of_set, 8'h00, next_rand(), next_rand());
         run(jcc, 1'b0, cond_e'(i), 8'(next_rand()), next_rand(), next_rand());
         run(add, 1'b0, of_set, 8'h00, next_rand(), next_rand());
         run(jcc, 1'b0, cond_e'(i), 8'(next_rand()), next_rand(), next_rand());
         run(shl, 1'b0, of_set, 8'(1 + next_rand() % 31), next_rand(), next_rand());
         run(jcc, 1'b0, cond_e'(i), 8'(next_rand()), next_rand(), next_rand());
      end
      run(jmp, 1'b0, of_set, 8'(next_rand()), next_rand(), next_rand());
      run(jmp_r, 1'b0, of_set, 8'(next_rand()), next_rand(), next_rand());
      run(cmp, 1'b0, of_set, 8'h00, 32'h1, 32'h0);   // borrow set, zf clear
      run(nop, 1'b0, of_set, 8'h00, next_rand(), next_rand());
      run(jcc, 1'b0, cf_set, 8'(next_rand()), next_rand(), next_rand());
      run(jcc, 1'b0, cf_clr, 8'(next_rand()), next_rand(), next_rand());
      hold_cycle();
      report_test("branches", e0);
   endtask

   task automatic hold_on_idle();
      int e0;
      e0 = n_errors;
      run(jmp, 1'b0, of_set, 8'(next_rand()), next_rand(), next_rand());
      repeat (3) hold_cycle();
      run(add, 1'b0, of_set, 8'h00, next_rand(), next_rand());
      repeat (3) hold_cycle();
      report_test("hold", e0);
   endtask

   initial begin
      rng_state = 32'h14b3_abbe;
      n_checks  = 0;
      n_errors  = 0;
      n_tests   = 0;
      m_dr      = '0;
      m_wb      = '0;
      m_jump    = 1'b0;
      m_flags   = '0;
      n_rst     = 1'b0;
      we        = 1'b0;
      ir        = '0;
      sr        = '0;
      tr        = '0;
      pc        = '0;
      repeat (3) @(posedge clk);
      n_rst <= 1'b1;
      after_reset();
      reg_forms();
      imm_forms();
      cond_jumps();
      hold_on_idle();
      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

endmodule

//--- execute.f
src/isa_pkg.sv
src/exec_pkg.sv
src/insn_decoder.sv
src/alu.sv
src/flag_unit.sv
src/branch_unit.sv
src/execute.sv
sim/tb_clock.sv
sim/execute_tb.sv
